// File: src/tpu_defs.svh
`ifndef TPU_DEFS_SVH
`define TPU_DEFS_SVH

// AXI4-Lite port widths
`define TPU_ADDR_W 8
`define TPU_DATA_W 32

// Register map, byte offsets on the slave port
`define TPU_REG_CTRL   8'h00
`define TPU_REG_STATUS 8'h04
`define TPU_REG_WEIGHT 8'h08
`define TPU_REG_INPUT  8'h0C
`define TPU_REG_RES0   8'h10
`define TPU_REG_RES1   8'h14

// Upper bound on the run phase, in cycles
`define TPU_DRAIN_CYCLES 8

// Cycles over which the skewed input rows are presented
`define TPU_STAGGER_DEPTH 3

`endif

// File: src/tpu_pkg.sv
`default_nettype none

`include "tpu_defs.svh"

package tpu_pkg;

  // Matrix element and wrapping 16-bit result
  typedef logic signed [7:0]  elem_t;
  typedef logic signed [15:0] psum_t;

  // 2x2 matrix in one word, element [0][0] in the low byte
  typedef struct packed {
    elem_t e11;
    elem_t e10;
    elem_t e01;
    elem_t e00;
  } quad_s;

  // Same word as written over AXI or as four elements
  typedef union packed {
    logic [`TPU_DATA_W-1:0] raw;
    quad_s                  q;
  } quad_u;

  // Host to slave, grouped by channel
  typedef struct packed {
    logic [`TPU_ADDR_W-1:0]     awaddr;
    logic                       awvalid;
    logic [`TPU_DATA_W-1:0]     wdata;
    logic [`TPU_DATA_W/8-1:0]   wstrb;
    logic                       wvalid;
    logic                       bready;
    logic [`TPU_ADDR_W-1:0]     araddr;
    logic                       arvalid;
    logic                       rready;
  } axil_req_t;

  // Slave to host
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   arready;
    logic [`TPU_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
  } axil_rsp_t;

  // Both results of one array column, row 0 low
  typedef struct packed {
    psum_t r1;
    psum_t r0;
  } acc_col_t;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_RUN
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/axil_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "tpu_defs.svh"

module axil_regs import tpu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output logic      start_req,
  output quad_u     weights,
  output quad_u     inputs,
  input  logic      busy,
  input  logic      done,
  input  acc_col_t  col0,
  input  acc_col_t  col1
);

  logic                   wr_hs;
  logic                   rd_hs;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic [`TPU_DATA_W-1:0] rdata_q;
  logic [`TPU_DATA_W-1:0] rd_word;

  // AW and W are taken together, only with no B outstanding
  assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  // One read in flight at a time
  assign rd_hs = axil_req.arvalid && !rvalid_q;

  // Start goes out in the handshake cycle itself
  // so the operand words are still the ones of this run
  assign start_req = wr_hs && (axil_req.awaddr == `TPU_REG_CTRL) && axil_req.wdata[0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // B held until the host takes it
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      // R held the same way
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Operand words, full word written whatever wstrb says
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      case (axil_req.awaddr)
        `TPU_REG_WEIGHT: weights.raw <= axil_req.wdata;
        `TPU_REG_INPUT:  inputs.raw  <= axil_req.wdata;
        default: ;
      endcase
    end
  end

  // Read decode, result rows built from both columns
  always_comb begin
    case (axil_req.araddr)
      `TPU_REG_STATUS: rd_word = {30'd0, done, busy};
      `TPU_REG_WEIGHT: rd_word = weights.raw;
      `TPU_REG_INPUT:  rd_word = inputs.raw;
      // C[0][1] high, C[0][0] low
      `TPU_REG_RES0:   rd_word = {col1.r0, col0.r0};
      `TPU_REG_RES1:   rd_word = {col1.r1, col0.r1};
      // CTRL start bit does not read back
      default:         rd_word = '0;
    endcase
  end

  // Data captured at AR and held while R waits
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = rd_hs;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rvalid  = rvalid_q;
    // Always OKAY
    axil_rsp.bresp   = 2'b00;
    axil_rsp.rresp   = 2'b00;
  end

  // Response stays up until the host accepts it
  bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid_q && !axil_req.bready |=> bvalid_q);

  // Read data is stable while R is stalled
  rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q));

endmodule

`default_nettype wire

// File: src/control_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "tpu_defs.svh"

module control_unit import tpu_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic start_req,
  input  logic full0,
  input  logic full1,
  output logic load_weight,
  output logic issue,
  output logic busy,
  output logic done
);

  // Last cycle count allowed in the run state
  localparam logic [3:0] RUN_LAST = 4'(`TPU_DRAIN_CYCLES - 1);

  ctrl_state_t state;
  logic [3:0]  run_cnt;
  logic        run_end;

  // Full flags still hold the previous run during the issue cycle
  assign run_end = (!issue && full0 && full1) || (run_cnt == RUN_LAST);

  assign load_weight = (state == ST_LOAD);
  assign busy        = (state != ST_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      issue   <= 1'b0;
      done    <= 1'b0;
      run_cnt <= '0;
    end else begin
      // Issue is the first cycle of the run state
      issue <= (state == ST_LOAD);
      case (state)
        ST_IDLE: begin
          run_cnt <= '0;
          // Starts while busy never reach here
          if (start_req) begin
            state <= ST_LOAD;
            done  <= 1'b0;
          end
        end
        ST_LOAD: begin
          state <= ST_RUN;
        end
        ST_RUN: begin
          run_cnt <= run_cnt + 4'd1;
          if (run_end) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Weights must settle before the first activation
  no_load_with_issue: assert property (@(posedge clk) disable iff (!arst_n)
    !(load_weight && issue));

  // Both columns finish before the drain guard fires
  drain_in_time: assert property (@(posedge clk) disable iff (!arst_n)
    (state == ST_RUN) && (run_cnt == RUN_LAST) |-> full0 && full1);

endmodule

`default_nettype wire

// File: src/input_setup.sv
`default_nettype none
`timescale 1ns/1ps

`include "tpu_defs.svh"

module input_setup import tpu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  issue,
  input  quad_u inputs,
  output elem_t a_in1,
  output elem_t a_in2,
  output logic  a_valid1,
  output logic  a_valid2
);

  // One-hot position in the skewed sequence
  logic [`TPU_STAGGER_DEPTH-1:0] phase;
  quad_s                         x_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= '0;
    end else begin
      phase <= {phase[`TPU_STAGGER_DEPTH-2:0], issue};
    end
  end

  // X snapshot, later host writes do not disturb the run
  always_ff @(posedge clk) begin
    if (issue) begin
      x_q <= inputs.q;
    end
  end

  // Row 0 carries column 0 of X, X[0][0] then X[1][0]
  assign a_valid1 = phase[0] | phase[1];
  assign a_in1    = phase[0] ? x_q.e00 : x_q.e10;

  // Row 1 carries column 1 of X, one cycle behind
  assign a_valid2 = phase[1] | phase[2];
  assign a_in2    = phase[1] ? x_q.e01 : x_q.e11;

endmodule

`default_nettype wire

// File: src/mmu.sv
`default_nettype none
`timescale 1ns/1ps

module mmu import tpu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  load_weight,
  input  quad_u weights,
  input  elem_t a_in1,
  input  elem_t a_in2,
  input  logic  a_valid1,
  input  logic  a_valid2,
  output psum_t col_out1,
  output psum_t col_out2,
  output logic  col_valid1,
  output logic  col_valid2
);

  // Cell [i][j] holds W[i][j]
  elem_t w_src [2][2];
  elem_t w_q   [2][2];
  // Activation and partial sum leaving each cell
  elem_t act_q [2][2];
  psum_t ps_q  [2][2];
  // Per-cell valid, shared by both outputs of the cell
  logic [1:0][1:0] v_q;

  // What each cell sees this cycle
  elem_t a_src [2][2];
  psum_t p_src [2][2];
  logic [1:0][1:0] v_src;

  assign w_src[0][0] = weights.q.e00;
  assign w_src[0][1] = weights.q.e01;
  assign w_src[1][0] = weights.q.e10;
  assign w_src[1][1] = weights.q.e11;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 2; j++) begin
        // Left column takes the skewed rows, the right one its neighbour
        if (j == 0) begin
          a_src[i][j] = (i == 0) ? a_in1 : a_in2;
          v_src[i][j] = (i == 0) ? a_valid1 : a_valid2;
        end else begin
          a_src[i][j] = act_q[i][j-1];
          v_src[i][j] = v_q[i][j-1];
        end
        // Top row starts the sum from zero
        p_src[i][j] = (i == 0) ? psum_t'(0) : ps_q[i-1][j];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v_q <= '0;
    end else begin
      v_q <= v_src;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 2; j++) begin
        if (load_weight) begin
          w_q[i][j] <= w_src[i][j];
        end
        act_q[i][j] <= a_src[i][j];
        // Signed 16-bit multiply-add, overflow wraps
        ps_q[i][j]  <= p_src[i][j] + a_src[i][j] * w_q[i][j];
      end
    end
  end

  // Bottom row feeds the accumulators
  assign col_out1   = ps_q[1][0];
  assign col_out2   = ps_q[1][1];
  assign col_valid1 = v_q[1][0];
  assign col_valid2 = v_q[1][1];

endmodule

`default_nettype wire

// File: src/accumulator.sv
`default_nettype none
`timescale 1ns/1ps

module accumulator import tpu_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     clear,
  input  psum_t    acc_in,
  input  logic     acc_valid,
  output acc_col_t col,
  output logic     full
);

  // Next slot, 0 for row 0 and 1 for row 1
  logic wr_sel;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Results read back as zero until the first run
      col    <= '0;
      wr_sel <= 1'b0;
      full   <= 1'b0;
    end else if (clear) begin
      // Stored values stay readable until overwritten
      wr_sel <= 1'b0;
      full   <= 1'b0;
    end else if (acc_valid) begin
      if (wr_sel) begin
        col.r1 <= acc_in;
      end else begin
        col.r0 <= acc_in;
      end
      wr_sel <= ~wr_sel;
      // Second write fills the store
      full   <= wr_sel;
    end
  end

  // The array sends exactly two results per run
  no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
    acc_valid && !clear |-> !full);

endmodule

`default_nettype wire

// File: src/tpu.sv
`default_nettype none
`timescale 1ns/1ps

module tpu import tpu_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  axil_req_t s_axil_req,
  output axil_rsp_t s_axil_rsp
);

  // Host side
  logic     start_req;
  quad_u    weights;
  quad_u    inputs;

  // Sequencer outputs
  logic     load_weight;
  logic     issue;
  logic     busy;
  logic     done;

  // Skewed rows into the array
  elem_t    a_in1;
  elem_t    a_in2;
  logic     a_valid1;
  logic     a_valid2;

  // Column results out of the array
  psum_t    col_out1;
  psum_t    col_out2;
  logic     col_valid1;
  logic     col_valid2;

  // Stored columns and their full flags
  acc_col_t col0;
  acc_col_t col1;
  logic     full0;
  logic     full1;

  axil_regs regs_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .axil_req  (s_axil_req),
    .axil_rsp  (s_axil_rsp),
    .start_req (start_req),
    .weights   (weights),
    .inputs    (inputs),
    .busy      (busy),
    .done      (done),
    .col0      (col0),
    .col1      (col1)
  );

  control_unit ctrl_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .start_req   (start_req),
    .full0       (full0),
    .full1       (full1),
    .load_weight (load_weight),
    .issue       (issue),
    .busy        (busy),
    .done        (done)
  );

  input_setup setup_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (issue),
    .inputs   (inputs),
    .a_in1    (a_in1),
    .a_in2    (a_in2),
    .a_valid1 (a_valid1),
    .a_valid2 (a_valid2)
  );

  mmu mmu_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .load_weight (load_weight),
    .weights     (weights),
    .a_in1       (a_in1),
    .a_in2       (a_in2),
    .a_valid1    (a_valid1),
    .a_valid2    (a_valid2),
    .col_out1    (col_out1),
    .col_out2    (col_out2),
    .col_valid1  (col_valid1),
    .col_valid2  (col_valid2)
  );

  // Issue also empties both column stores
  accumulator acc0_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (issue),
    .acc_in    (col_out1),
    .acc_valid (col_valid1),
    .col       (col0),
    .full      (full0)
  );

  accumulator acc1_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (issue),
    .acc_in    (col_out2),
    .acc_valid (col_valid2),
    .col       (col1),
    .full      (full1)
  );

endmodule

`default_nettype wire

// File: tests/tb_tpu.sv
`default_nettype none
`timescale 1ns/1ps

`include "tpu_defs.svh"

module tb_tpu import tpu_pkg::*; ();

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DELAY   = 10;
  localparam int RESET_CYCLES  = 16;
  localparam int RAND_RUNS     = 50;
  // Identity, two corners and the busy case
  localparam int DIRECTED_RUNS = 4;
  localparam int NUM_RUNS      = RAND_RUNS + DIRECTED_RUNS;
  localparam int HS_LIMIT      = 20;
  localparam int POLL_LIMIT    = 40;

  logic      clk;
  logic      arst_n;
  axil_req_t req;
  axil_rsp_t rsp;

  int value_errs;
  int proto_errs;
  int seed;

  // Reads waiting for the checker
  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];
  string       tag_q [$];

  tpu dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_axil_req (req),
    .s_axil_rsp (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // C = X*W cut to 16 bits with RES1 in the upper word and RES0 in the lower
  function automatic logic [63:0] ref_product(input logic [31:0] x, input logic [31:0] w);
    int          xe [2][2];
    int          we [2][2];
    logic [15:0] c  [2][2];
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < 2; k++) begin
        // Element [r][k] sits in byte 2r+k
        xe[r][k] = int'($signed(x[8*(2*r+k) +: 8]));
        we[r][k] = int'($signed(w[8*(2*r+k) +: 8]));
      end
    end
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < 2; k++) begin
        c[r][k] = 16'(xe[r][0] * we[0][k] + xe[r][1] * we[1][k]);
      end
    end
    return {c[1][1], c[1][0], c[0][1], c[0][0]};
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int stall);
    int cnt;
    @(posedge clk);
    #DRIVE_DELAY;
    req.awaddr  = addr;
    req.awvalid = 1'b1;
    req.wdata   = data;
    req.wstrb   = strb;
    req.wvalid  = 1'b1;
    // No stall means B is taken the cycle it shows
    req.bready  = (stall == 0);
    cnt = 0;
    @(negedge clk);
    // AW and W are accepted in the same cycle
    while (!(rsp.awready && rsp.wready) && cnt < HS_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!(rsp.awready && rsp.wready)) begin
      $display("Write to 0x%02h was never accepted on both AW and W by the DUT", addr);
      proto_errs++;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!rsp.bvalid && cnt < HS_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rsp.bvalid) begin
      $display("No write response came back for 0x%02h", addr);
      proto_errs++;
    end
    if (rsp.bresp != 2'b00) begin
      $display("** Error: time %0t: write 0x%02h bresp %0b, expected OKAY", $time, addr,
               rsp.bresp);
      value_errs++;
    end
    // B must stay up while bready is low
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!rsp.bvalid) begin
        $display("Write response for 0x%02h dropped before bready", addr);
        proto_errs++;
      end
    end
    if (stall != 0) begin
      @(posedge clk);
      #DRIVE_DELAY;
      req.bready = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    req.bready = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input int stall, output logic [31:0] data);
    int cnt;
    @(posedge clk);
    #DRIVE_DELAY;
    req.araddr  = addr;
    req.arvalid = 1'b1;
    req.rready  = (stall == 0);
    cnt = 0;
    @(negedge clk);
    while (!rsp.arready && cnt < HS_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rsp.arready) begin
      $display("Read of 0x%02h was never accepted by the DUT", addr);
      proto_errs++;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    req.arvalid = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!rsp.rvalid && cnt < HS_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rsp.rvalid) begin
      $display("No read data came back for 0x%02h", addr);
      proto_errs++;
    end
    data = rsp.rdata;
    if (rsp.rresp != 2'b00) begin
      $display("** Error: time %0t: read 0x%02h rresp %0b, expected OKAY", $time, addr,
               rsp.rresp);
      value_errs++;
    end
    // R held and unchanged while rready is low
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!rsp.rvalid) begin
        $display("Read data for 0x%02h dropped before rready", addr);
        proto_errs++;
      end
      if (rsp.rdata !== data) begin
        $display("** Error: time %0t: stalled rdata 0x%08h moved to 0x%08h", $time, data,
                 rsp.rdata);
        value_errs++;
      end
    end
    if (stall != 0) begin
      @(posedge clk);
      #DRIVE_DELAY;
      req.rready = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    req.rready = 1'b0;
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] expected,
                            input string tag, input int stall);
    logic [31:0] got;
    read_reg(addr, stall, got);
    exp_q.push_back(expected);
    got_q.push_back(got);
    tag_q.push_back(tag);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      read_reg(`TPU_REG_STATUS, 0, status);
      polls++;
    end
    if (!status[1]) begin
      $display("Run never reported done after %0d status polls", polls);
      proto_errs++;
    end
  endtask

  task automatic run_matrix(input logic [31:0] x, input logic [31:0] w,
                            input logic [3:0] strb, input string tag);
    logic [63:0] expv;
    expv = ref_product(x, w);
    write_reg(`TPU_REG_WEIGHT, w, strb, 0);
    write_reg(`TPU_REG_INPUT, x, strb, 0);
    write_reg(`TPU_REG_CTRL, 32'h1, 4'hF, 0);
    wait_done();
    check_read(`TPU_REG_RES0, expv[31:0], {tag, " RES0"}, 0);
    check_read(`TPU_REG_RES1, expv[63:32], {tag, " RES1"}, 0);
  endtask

  // Checker draining queued reads once per cycle
  initial begin
    logic [31:0] exp_w;
    logic [31:0] got_w;
    string       tag;
    forever begin
      @(negedge clk);
      while (got_q.size() != 0) begin
        exp_w = exp_q.pop_front();
        got_w = got_q.pop_front();
        tag   = tag_q.pop_front();
        if (got_w !== exp_w) begin
          $display("** Error: time %0t: %s read 0x%08h, expected 0x%08h", $time, tag, got_w,
                   exp_w);
          value_errs++;
        end
      end
    end
  end

  initial begin
    logic [31:0] x;
    logic [31:0] w;
    logic [63:0] expv;
    value_errs = 0;
    proto_errs = 0;
    seed       = 32'h4233;
    req        = '0;
    arst_n     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    check_read(`TPU_REG_STATUS, 32'h0, "STATUS after reset", 0);
    check_read(`TPU_REG_RES0, 32'h0, "RES0 after reset", 0);
    check_read(`TPU_REG_RES1, 32'h0, "RES1 after reset", 0);

    // Partial strobes still write whole words
    run_matrix(32'h807F_FE05, 32'h0100_0001, 4'h1, "identity");
    // Sum of two 16384 products wraps to -32768
    run_matrix(32'h8080_8080, 32'h8080_8080, 4'hF, "all -128");
    run_matrix(32'h7F81_817F, 32'h817F_7F81, 4'h6, "mixed +-127");

    for (int n = 0; n < RAND_RUNS; n++) begin
      x = $random(seed);
      w = $random(seed);
      run_matrix(x, w, 4'hF, $sformatf("random run %0d", n));
    end

    // New weights and then a second start land while the first run is busy
    // An accepted second start would load the new weights
    x    = $random(seed);
    w    = $random(seed);
    expv = ref_product(x, w);
    write_reg(`TPU_REG_WEIGHT, w, 4'hF, 0);
    write_reg(`TPU_REG_INPUT, x, 4'hF, 0);
    write_reg(`TPU_REG_CTRL, 32'h1, 4'hF, 0);
    write_reg(`TPU_REG_WEIGHT, ~w, 4'hF, 0);
    write_reg(`TPU_REG_CTRL, 32'h1, 4'hF, 0);
    wait_done();
    check_read(`TPU_REG_RES0, expv[31:0], "busy start RES0", 0);
    check_read(`TPU_REG_RES1, expv[63:32], "busy start RES1", 0);

    // Stalled responses, read-only and unknown offsets
    check_read(`TPU_REG_RES0, expv[31:0], "stalled RES0", 5);
    write_reg(`TPU_REG_STATUS, 32'hFFFF_FFFF, 4'hF, 4);
    check_read(`TPU_REG_STATUS, 32'h2, "STATUS after write", 0);
    check_read(`TPU_REG_RES1, expv[63:32], "RES1 after STATUS write", 3);
    check_read(8'h18, 32'h0, "unknown 0x18", 0);
    check_read(8'h3C, 32'h0, "unknown 0x3C", 2);

    repeat (2) @(negedge clk);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog allows 200 cycles per run plus room for reset and the handshake checks
  initial begin
    #((NUM_RUNS + 4) * 200 * CLK_PERIOD);
    $display("Watchdog expired with the run unfinished, %0d value and %0d protocol errors",
             value_errs, proto_errs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/tpu_pkg.sv
src/axil_regs.sv
src/control_unit.sv
src/input_setup.sv
src/mmu.sv
src/accumulator.sv
src/tpu.sv
tests/tb_tpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the tpu testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tpu -f sim.f -o tb_tpu

./obj_dir/tb_tpu | tee sim.log

# The testbench reports failure in the log
if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
